/* hdl/osd_consts.svh */
// OSD configuration constants: status bit map, HDMI crop target and user-port idle level
`ifndef OSD_CONSTS_SVH
`define OSD_CONSTS_SVH

// Width of the OSD status word as seen by the core
`define OSD_STATUS_W        48

// Status word bit positions
`define OSD_BIT_FX_LSB      3   // Scan-line effect
`define OSD_BIT_FX_MSB      5
`define OSD_BIT_HSIZE_EN    19  // Horizontal scaling enable
`define OSD_BIT_DB15_EN     37
`define OSD_BIT_UART_EN     38
`define OSD_BIT_FLIP_LSB    38  // Rotate options, shares bit 38 with the UART switch
`define OSD_BIT_CROP_EN     41
`define OSD_BIT_VCOPT_LSB   42  // 4-bit vertical crop option
`define OSD_BIT_SCALE_LSB   46  // 2-bit scale mode

// Rotate-option code that requests a flipped frame buffer
`define OSD_FLIP_CODE       2'd2

// Only a 1080p HDMI output is cropped
`define HDMI_CROP_W         12'd1920
`define HDMI_CROP_H         12'd1080

// 1080 / 5 lines, giving 216p
`define CROP_LINES          12'd216

// vcopt values from here on map to negative offsets
`define VCOPT_WRAP          4'd6
`define CROP_OFF_ADJ        5'd24

// All user-port pins released
`define USER_IDLE           7'h7f

`endif

/* hdl/board_cfg_pkg.sv */
// Board configuration types for the OSD status word and the user port
`include "osd_consts.svh"

package board_cfg_pkg;

    // Low part of the HPS status word
    typedef logic [`OSD_STATUS_W-1:0] status_t;

    // USER_IN / USER_OUT pin vector
    typedef logic [6:0] user_port_t;

    // Vertical crop position option
    typedef logic [3:0] vcopt_t;

    // Scan-line effect selection, 0 is none
    typedef logic [`OSD_BIT_FX_MSB-`OSD_BIT_FX_LSB:0] fx_t;

    // Rotate-option field
    typedef logic [1:0] flip_sel_t;

endpackage

/* hdl/video_crop_pkg.sv */
// Video dimension and vertical-crop result types for the HDMI scaler side
package video_crop_pkg;

    // HDMI width or height as reported by the scaler
    typedef logic [11:0] dim_t;

    // Number of lines kept after crop, 0 disables it
    typedef logic [11:0] crop_size_t;

    // Two's complement offset in the -16..+15 range
    typedef logic [4:0] crop_off_t;

    // 0 normal, 1 V-integer, 2..4 HV-integer modes
    typedef logic [2:0] crop_scale_t;

    // A set bit hides the matching OSD menu item
    typedef logic [15:0] menu_mask_t;

endpackage

/* hdl/osd_cfg_if.sv */
// Decoded OSD settings shared between the status decoder and the video and port blocks
`timescale 1ns/1ns

interface osd_cfg_if;

    logic                        crop_en;     // User crop switch
    board_cfg_pkg::vcopt_t       vcopt;
    video_crop_pkg::crop_scale_t crop_scale;
    board_cfg_pkg::fx_t          fx;
    logic                        hsize_en;
    logic                        uart_en;
    logic                        db15_en;
    board_cfg_pkg::flip_sel_t    flip_sel;

    // Decoder owns every field
    modport dec (
        output crop_en, vcopt, crop_scale, fx,
        output hsize_en, uart_en, db15_en, flip_sel
    );

    // Crop decision
    modport crop (
        input crop_en, vcopt, crop_scale, fx
    );

    // User-port mux
    modport port (
        input uart_en, db15_en
    );

    // Menu mask and frame-buffer flip
    modport menu (
        input hsize_en, flip_sel
    );

endinterface

/* hdl/status_decode.sv */
// OSD status decoder that registers the used status fields onto the settings bus
`timescale 1ns/1ns
`include "osd_consts.svh"

module status_decode (
    input  logic                   clk_sys,
    input  logic                   arst_n,
    input  board_cfg_pkg::status_t status,
    osd_cfg_if.dec                 cfg
);

    localparam int VCOPT_W = $bits(board_cfg_pkg::vcopt_t);
    localparam int FLIP_W  = $bits(board_cfg_pkg::flip_sel_t);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            cfg.crop_en    <= 1'b0;
            cfg.vcopt      <= '0;
            cfg.crop_scale <= '0;
            cfg.fx         <= '0;
            cfg.hsize_en   <= 1'b0;
            cfg.uart_en    <= 1'b0;
            cfg.db15_en    <= 1'b0;
            cfg.flip_sel   <= '0;
        end else begin
            // Vertical crop controls
            cfg.crop_en    <= status[`OSD_BIT_CROP_EN];
            cfg.vcopt      <= status[`OSD_BIT_VCOPT_LSB +: VCOPT_W];
            cfg.crop_scale <= {1'b0, status[`OSD_BIT_SCALE_LSB +: 2]};
            cfg.fx         <= status[`OSD_BIT_FX_MSB:`OSD_BIT_FX_LSB];

            cfg.hsize_en   <= status[`OSD_BIT_HSIZE_EN];

            // UART switch also lives in the rotate field
            cfg.uart_en    <= status[`OSD_BIT_UART_EN];
            cfg.db15_en    <= status[`OSD_BIT_DB15_EN];
            cfg.flip_sel   <= status[`OSD_BIT_FLIP_LSB +: FLIP_W];
        end
    end

    // The user-port mux needs at least one defined switch once running
    a_port_sel_known : assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        !($isunknown(cfg.db15_en) && $isunknown(cfg.uart_en))
    ) else $error("db15_en and uart_en both unknown");

endmodule

/* hdl/crop_calc.sv */
// HDMI vertical crop decision with crop line count and signed line offset
`timescale 1ns/1ns
`include "osd_consts.svh"

module crop_calc (
    input  logic                       clk_sys,
    input  logic                       arst_n,
    osd_cfg_if.crop                    cfg,
    input  video_crop_pkg::dim_t       hdmi_width,
    input  video_crop_pkg::dim_t       hdmi_height,
    input  logic                       force_scan2x,
    input  logic                       direct_video,
    input  logic                       rotate_en,
    output logic                       crop_ok,
    output video_crop_pkg::crop_size_t crop_size,
    output video_crop_pkg::crop_off_t  crop_off
);

    logic                      size_1080p;
    logic                      video_plain;   // No setting that fights with cropping
    video_crop_pkg::crop_off_t vcopt_x2;

    assign size_1080p  = (hdmi_width == `HDMI_CROP_W) && (hdmi_height == `HDMI_CROP_H);

    assign video_plain = (cfg.fx == '0) && !force_scan2x && (cfg.crop_scale == '0)
                         && !direct_video && !rotate_en;

    // Offset steps by two lines per option
    assign vcopt_x2 = {cfg.vcopt, 1'b0};

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            crop_ok  <= 1'b0;
            crop_off <= '0;
        end else begin
            crop_ok  <= size_1080p && video_plain;
            // Upper options wrap to negative offsets, 5-bit arithmetic
            crop_off <= (cfg.vcopt < `VCOPT_WRAP) ? vcopt_x2 : vcopt_x2 - `CROP_OFF_ADJ;
        end
    end

    // Uses the registered decision, so one cycle behind crop_ok
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            crop_size <= '0;
        end else if (crop_ok && cfg.crop_en) begin
            crop_size <= `CROP_LINES;
        end else begin
            crop_size <= '0;
        end
    end

    a_size_needs_ok : assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        (crop_size != '0) |-> $past(crop_ok)
    ) else $error("crop_size set without a prior crop_ok");

endmodule

/* hdl/user_port_ctrl.sv */
// User-port output mux between DB15 joystick, game UART and idle, with UART receive gating
`timescale 1ns/1ns
`include "osd_consts.svh"

module user_port_ctrl (
    input  logic                      clk_sys,
    input  logic                      arst_n,
    osd_cfg_if.port                   cfg,
    input  board_cfg_pkg::user_port_t user_in,
    input  board_cfg_pkg::user_port_t db15_joy,
    input  logic                      game_tx,
    output board_cfg_pkg::user_port_t user_out,
    output logic                      game_rx
);

    // DB15 wins over the UART, idle releases every pin
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            user_out <= `USER_IDLE;
        end else if (cfg.db15_en) begin
            user_out <= db15_joy;          // Joystick shift-register pattern
        end else if (cfg.uart_en) begin
            user_out <= {6'h3f, game_tx};  // TX on pin 0
        end else begin
            user_out <= `USER_IDLE;
        end
    end

    // RX on pin 1, held at the UART idle level when off
    assign game_rx = cfg.uart_en ? user_in[1] : 1'b1;

    a_uart_pins_high : assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        (cfg.uart_en && !cfg.db15_en) |=> (user_out[6:1] == 6'h3f)
    ) else $error("user_out upper pins not released in UART mode");

endmodule

/* hdl/menu_mask_gen.sv */
// OSD menu-hide mask builder and frame-buffer flip flag
`timescale 1ns/1ns
`include "osd_consts.svh"

module menu_mask_gen #(
    parameter int ROTATE_MENU = 0   // 1 shows the extra rotate options for vertical games
) (
    input  logic                       clk_sys,
    input  logic                       arst_n,
    osd_cfg_if.menu                    cfg,
    input  logic                       crop_ok,
    input  logic                       core_vertical,
    input  logic                       direct_video,
    output video_crop_pkg::menu_mask_t status_menumask,
    output logic                       framebuf_flip
);

    video_crop_pkg::menu_mask_t mask_d;
    video_crop_pkg::menu_mask_t mask_q;

    always_comb begin
        mask_d    = '0;
        mask_d[5] = crop_ok;           // Video crop options
        mask_d[2] = ~cfg.hsize_en;     // Horizontal scaling
        mask_d[0] = direct_video;
        if (ROTATE_MENU != 0) begin
            mask_d[4] = ~core_vertical;
            mask_d[1] = 1'b1;
        end else begin
            mask_d[4] = 1'b1;
            mask_d[1] = ~core_vertical;
        end
    end

    // Two stages so the mask reaches the HPS side already settled
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            mask_q          <= '0;
            status_menumask <= '0;
            framebuf_flip   <= 1'b0;
        end else begin
            mask_q          <= mask_d;
            status_menumask <= mask_q;
            framebuf_flip   <= (cfg.flip_sel == `OSD_FLIP_CODE);
        end
    end

    a_unused_bits_zero : assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        (status_menumask[15:6] == '0) && !status_menumask[3]
    ) else $error("reserved menu mask bits set");

endmodule

/* hdl/osd_video_ctrl.sv */
// OSD configuration slice with user-port control, HDMI vertical crop and menu mask
`timescale 1ns/1ns

module osd_video_ctrl #(
    parameter int ROTATE_MENU = 0
) (
    input  logic                       clk_sys,
    input  logic                       arst_n,
    input  board_cfg_pkg::status_t     status,
    input  logic                       core_vertical,
    input  logic                       direct_video,
    input  logic                       force_scan2x,
    input  logic                       rotate_en,
    input  video_crop_pkg::dim_t       hdmi_width,
    input  video_crop_pkg::dim_t       hdmi_height,
    // User port
    input  board_cfg_pkg::user_port_t  user_in,
    input  board_cfg_pkg::user_port_t  db15_joy,
    input  logic                       game_tx,
    output board_cfg_pkg::user_port_t  user_out,
    output logic                       game_rx,
    output logic                       uart_en,
    output logic                       db15_en,
    // HDMI crop
    output video_crop_pkg::crop_size_t crop_size,
    output video_crop_pkg::crop_off_t  crop_off,
    // OSD
    output video_crop_pkg::menu_mask_t status_menumask,
    output logic                       framebuf_flip
);

    logic crop_ok;

    osd_cfg_if cfg_bus ();

    assign uart_en = cfg_bus.uart_en;
    assign db15_en = cfg_bus.db15_en;

    status_decode u_decode (
        .clk_sys    ( clk_sys   ),
        .arst_n     ( arst_n    ),
        .status     ( status    ),
        .cfg        ( cfg_bus   )
    );

    crop_calc u_crop (
        .clk_sys      ( clk_sys      ),
        .arst_n       ( arst_n       ),
        .cfg          ( cfg_bus      ),
        .hdmi_width   ( hdmi_width   ),
        .hdmi_height  ( hdmi_height  ),
        .force_scan2x ( force_scan2x ),
        .direct_video ( direct_video ),
        .rotate_en    ( rotate_en    ),
        .crop_ok      ( crop_ok      ),
        .crop_size    ( crop_size    ),
        .crop_off     ( crop_off     )
    );

    user_port_ctrl u_user (
        .clk_sys    ( clk_sys   ),
        .arst_n     ( arst_n    ),
        .cfg        ( cfg_bus   ),
        .user_in    ( user_in   ),
        .db15_joy   ( db15_joy  ),
        .game_tx    ( game_tx   ),
        .user_out   ( user_out  ),
        .game_rx    ( game_rx   )
    );

    menu_mask_gen #(
        .ROTATE_MENU ( ROTATE_MENU )
    ) u_menu (
        .clk_sys         ( clk_sys         ),
        .arst_n          ( arst_n          ),
        .cfg             ( cfg_bus         ),
        .crop_ok         ( crop_ok         ),
        .core_vertical   ( core_vertical   ),
        .direct_video    ( direct_video    ),
        .status_menumask ( status_menumask ),
        .framebuf_flip   ( framebuf_flip   )
    );

endmodule

/* sim/tb_vectors.svh */
// Directed stimulus table for the OSD configuration testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One stimulus entry with a name and every top-level input
typedef struct {
    string                     name;
    board_cfg_pkg::status_t    status;
    logic                      core_vertical;
    logic                      direct_video;
    logic                      force_scan2x;
    logic                      rotate_en;
    video_crop_pkg::dim_t      hdmi_width;
    video_crop_pkg::dim_t      hdmi_height;
    board_cfg_pkg::user_port_t user_in;
    board_cfg_pkg::user_port_t db15_joy;
    logic                      game_tx;
} vec_t;

localparam int N_DIRECTED = 12;

function automatic board_cfg_pkg::status_t pack_status(
    input logic [1:0] scale,
    input logic [3:0] vcopt,
    input logic       crop_en,
    input logic [1:0] rot_opt,   // Bits 39:38, bit 38 doubles as the UART switch
    input logic       db15_en,
    input logic       hsize_en,
    input logic [2:0] fx
);
    board_cfg_pkg::status_t s;
    s = '0;
    s[`OSD_BIT_SCALE_LSB +: 2]         = scale;
    s[`OSD_BIT_VCOPT_LSB +: 4]         = vcopt;
    s[`OSD_BIT_CROP_EN]                = crop_en;
    s[`OSD_BIT_FLIP_LSB +: 2]          = rot_opt;
    s[`OSD_BIT_DB15_EN]                = db15_en;
    s[`OSD_BIT_HSIZE_EN]               = hsize_en;
    s[`OSD_BIT_FX_MSB:`OSD_BIT_FX_LSB] = fx;
    return s;
endfunction

// Fields: name, status, core_vertical, direct_video, force_scan2x, rotate_en,
// hdmi_width, hdmi_height, user_in, db15_joy, game_tx
function automatic vec_t directed_vector(input int idx);
    vec_t v;
    case (idx)
        0: v = '{"crop_on", pack_status(2'd0, 4'd0, 1'b1, 2'd0, 1'b0, 1'b1, 3'd0),
                 1'b0, 1'b0, 1'b0, 1'b0, 12'd1920, 12'd1080, 7'h00, 7'h00, 1'b0};
        1: v = '{"crop_en_clear", pack_status(2'd0, 4'd3, 1'b0, 2'd0, 1'b0, 1'b1, 3'd0),
                 1'b0, 1'b0, 1'b0, 1'b0, 12'd1920, 12'd1080, 7'h00, 7'h00, 1'b0};
        2: v = '{"crop_width", pack_status(2'd0, 4'd5, 1'b1, 2'd0, 1'b0, 1'b1, 3'd0),
                 1'b0, 1'b0, 1'b0, 1'b0, 12'd1280, 12'd1080, 7'h00, 7'h00, 1'b0};
        3: v = '{"crop_fx", pack_status(2'd0, 4'd6, 1'b1, 2'd0, 1'b0, 1'b1, 3'd3),
                 1'b0, 1'b0, 1'b0, 1'b0, 12'd1920, 12'd1080, 7'h00, 7'h00, 1'b0};
        4: v = '{"crop_scan2x", pack_status(2'd0, 4'd15, 1'b1, 2'd0, 1'b0, 1'b1, 3'd0),
                 1'b0, 1'b0, 1'b1, 1'b0, 12'd1920, 12'd1080, 7'h00, 7'h00, 1'b0};
        5: v = '{"crop_scale", pack_status(2'd1, 4'd10, 1'b1, 2'd0, 1'b0, 1'b1, 3'd0),
                 1'b0, 1'b0, 1'b0, 1'b0, 12'd1920, 12'd1080, 7'h00, 7'h00, 1'b0};
        6: v = '{"crop_direct", pack_status(2'd0, 4'd2, 1'b1, 2'd0, 1'b0, 1'b0, 3'd0),
                 1'b0, 1'b1, 1'b0, 1'b0, 12'd1920, 12'd1080, 7'h00, 7'h00, 1'b0};
        7: v = '{"crop_rotate", pack_status(2'd0, 4'd8, 1'b1, 2'd0, 1'b0, 1'b1, 3'd0),
                 1'b1, 1'b0, 1'b0, 1'b1, 12'd1920, 12'd1080, 7'h00, 7'h00, 1'b0};
        8: v = '{"db15_pass", pack_status(2'd0, 4'd0, 1'b0, 2'd1, 1'b1, 1'b1, 3'd0),
                 1'b0, 1'b0, 1'b0, 1'b0, 12'd1920, 12'd1080, 7'h00, 7'h2a, 1'b1};
        9: v = '{"uart_tx_low", pack_status(2'd0, 4'd0, 1'b0, 2'd1, 1'b0, 1'b1, 3'd0),
                 1'b0, 1'b0, 1'b0, 1'b0, 12'd1920, 12'd720, 7'h02, 7'h00, 1'b0};
        10: v = '{"uart_tx_high", pack_status(2'd0, 4'd0, 1'b0, 2'd3, 1'b0, 1'b1, 3'd0),
                  1'b0, 1'b0, 1'b0, 1'b0, 12'd1920, 12'd1080, 7'h7d, 7'h00, 1'b1};
        default: v = '{"flip_idle", pack_status(2'd0, 4'd0, 1'b0, 2'd2, 1'b0, 1'b0, 3'd0),
                       1'b1, 1'b0, 1'b0, 1'b0, 12'd1920, 12'd1080, 7'h00, 7'h15, 1'b0};
    endcase
    return v;
endfunction

`endif

/* sim/tb_osd_video_ctrl.sv */
// Self-checking testbench for the OSD configuration, user-port and crop slice
`timescale 1ns/1ns
`include "osd_consts.svh"

module tb_osd_video_ctrl;

    `include "tb_vectors.svh"

    localparam int N_VEC          = 24;
    localparam int HOLD_CYCLES    = 6;
    localparam int TIMEOUT_CYCLES = N_VEC * 8 + 3 + 20;

    typedef struct {
        board_cfg_pkg::user_port_t  user_out;
        logic                       game_rx;
        logic                       uart_en;
        logic                       db15_en;
        video_crop_pkg::crop_size_t crop_size;
        video_crop_pkg::crop_off_t  crop_off;
        video_crop_pkg::menu_mask_t menu_mask;
        logic                       flip;
    } exp_t;

    logic                       clk_sys;
    logic                       arst_n;
    board_cfg_pkg::status_t     status;
    logic                       core_vertical;
    logic                       direct_video;
    logic                       force_scan2x;
    logic                       rotate_en;
    video_crop_pkg::dim_t       hdmi_width;
    video_crop_pkg::dim_t       hdmi_height;
    board_cfg_pkg::user_port_t  user_in;
    board_cfg_pkg::user_port_t  db15_joy;
    logic                       game_tx;
    board_cfg_pkg::user_port_t  user_out;
    logic                       game_rx;
    logic                       uart_en;
    logic                       db15_en;
    video_crop_pkg::crop_size_t crop_size;
    video_crop_pkg::crop_off_t  crop_off;
    video_crop_pkg::menu_mask_t status_menumask;
    logic                       framebuf_flip;

    vec_t        vectors[N_VEC];
    logic [31:0] rng_state   = 32'd35167;
    int          error_count = 0;
    int          failed_tests = 0;
    int          cycle_count = 0;

    osd_video_ctrl #(
        .ROTATE_MENU ( 0 )
    ) osd_video_ctrl_inst (
        .clk_sys         ( clk_sys         ),
        .arst_n          ( arst_n          ),
        .status          ( status          ),
        .core_vertical   ( core_vertical   ),
        .direct_video    ( direct_video    ),
        .force_scan2x    ( force_scan2x    ),
        .rotate_en       ( rotate_en       ),
        .hdmi_width      ( hdmi_width      ),
        .hdmi_height     ( hdmi_height     ),
        .user_in         ( user_in         ),
        .db15_joy        ( db15_joy        ),
        .game_tx         ( game_tx         ),
        .user_out        ( user_out        ),
        .game_rx         ( game_rx         ),
        .uart_en         ( uart_en         ),
        .db15_en         ( db15_en         ),
        .crop_size       ( crop_size       ),
        .crop_off        ( crop_off        ),
        .status_menumask ( status_menumask ),
        .framebuf_flip   ( framebuf_flip   )
    );

    always #4 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic build_vector_table();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        vec_t        v;
        for (int i = 0; i < N_DIRECTED; i++) begin
            vectors[i] = directed_vector(i);
        end
        for (int i = N_DIRECTED; i < N_VEC; i++) begin
            rng_state = xorshift32(rng_state);
            r1 = rng_state;
            rng_state = xorshift32(rng_state);
            r2 = rng_state;
            rng_state = xorshift32(rng_state);
            r3 = rng_state;
            v.name          = $sformatf("random_%0d", i - N_DIRECTED);
            v.status        = {r2[15:0], r1};
            v.core_vertical = r3[0];
            v.user_in       = r3[26:20];
            v.db15_joy      = {r3[31:27], r2[31:30]};
            v.game_tx       = r3[7];
            if (r2[16]) begin
                // 1080p with fx and scale cleared, so crop cases come up
                v.hdmi_width   = `HDMI_CROP_W;
                v.hdmi_height  = `HDMI_CROP_H;
                v.status[`OSD_BIT_FX_MSB:`OSD_BIT_FX_LSB] = 3'd0;
                v.status[`OSD_BIT_SCALE_LSB +: 2]         = 2'd0;
                v.force_scan2x = r3[1] & r3[2];
                v.direct_video = r3[3] & r3[4];
                v.rotate_en    = r3[5] & r3[6];
            end else begin
                v.hdmi_width   = r3[19:8];
                v.hdmi_height  = {1'b0, r2[27:17]};
                v.force_scan2x = r3[1];
                v.direct_video = r3[3];
                v.rotate_en    = r3[5];
            end
            vectors[i] = v;
        end
    endtask

    function automatic exp_t reference_outputs(input vec_t v);
        exp_t       e;
        logic       crop_ok;
        logic       uart;
        logic       db15;
        logic [3:0] vcopt;
        int         off;
        uart    = v.status[`OSD_BIT_UART_EN];
        db15    = v.status[`OSD_BIT_DB15_EN];
        vcopt   = v.status[`OSD_BIT_VCOPT_LSB +: 4];
        crop_ok = (v.hdmi_width == `HDMI_CROP_W) && (v.hdmi_height == `HDMI_CROP_H)
                  && (v.status[`OSD_BIT_FX_MSB:`OSD_BIT_FX_LSB] == 3'd0) && !v.force_scan2x
                  && (v.status[`OSD_BIT_SCALE_LSB +: 2] == 2'd0)
                  && !v.direct_video && !v.rotate_en;
        e.crop_size = (crop_ok && v.status[`OSD_BIT_CROP_EN]) ? `CROP_LINES : 12'd0;
        off = 2 * int'(vcopt);
        if (vcopt >= `VCOPT_WRAP) begin
            off = off - int'(`CROP_OFF_ADJ);  // Wraps modulo 32 below
        end
        e.crop_off = off[4:0];
        e.uart_en  = uart;
        e.db15_en  = db15;
        if (db15) begin
            e.user_out = v.db15_joy;
        end else if (uart) begin
            e.user_out = {6'h3f, v.game_tx};
        end else begin
            e.user_out = `USER_IDLE;
        end
        e.game_rx = uart ? v.user_in[1] : 1'b1;
        // Mapping for ROTATE_MENU = 0
        e.menu_mask    = '0;
        e.menu_mask[5] = crop_ok;
        e.menu_mask[4] = 1'b1;
        e.menu_mask[2] = ~v.status[`OSD_BIT_HSIZE_EN];
        e.menu_mask[1] = ~v.core_vertical;
        e.menu_mask[0] = v.direct_video;
        e.flip = (v.status[`OSD_BIT_FLIP_LSB +: 2] == `OSD_FLIP_CODE);
        return e;
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s %s: expected 0x%0h, actual 0x%0h",
                     test, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_outputs(input string test, input exp_t e);
        check_value(test, "user_out", 32'(e.user_out), 32'(user_out));
        check_value(test, "game_rx", 32'(e.game_rx), 32'(game_rx));
        check_value(test, "uart_en", 32'(e.uart_en), 32'(uart_en));
        check_value(test, "db15_en", 32'(e.db15_en), 32'(db15_en));
        check_value(test, "crop_size", 32'(e.crop_size), 32'(crop_size));
        check_value(test, "crop_off", 32'(e.crop_off), 32'(crop_off));
        check_value(test, "status_menumask", 32'(e.menu_mask), 32'(status_menumask));
        check_value(test, "framebuf_flip", 32'(e.flip), 32'(framebuf_flip));
    endtask

    task automatic report_test(input string test, input int errs_before);
        if (error_count == errs_before) begin
            $display("%-16s ok", test);
        end else begin
            $display("%-16s mismatch", test);
            failed_tests++;
        end
    endtask

    task automatic apply_vector(input vec_t v);
        status        = v.status;
        core_vertical = v.core_vertical;
        direct_video  = v.direct_video;
        force_scan2x  = v.force_scan2x;
        rotate_en     = v.rotate_en;
        hdmi_width    = v.hdmi_width;
        hdmi_height   = v.hdmi_height;
        user_in       = v.user_in;
        db15_joy      = v.db15_joy;
        game_tx       = v.game_tx;
    endtask

    initial begin
        exp_t reset_exp;
        int   errs_before;
        clk_sys       = 1'b0;
        arst_n        = 1'b0;
        status        = '0;
        core_vertical = 1'b0;
        direct_video  = 1'b0;
        force_scan2x  = 1'b0;
        rotate_en     = 1'b0;
        hdmi_width    = '0;
        hdmi_height   = '0;
        user_in       = '0;
        db15_joy      = '0;
        game_tx       = 1'b0;
        build_vector_table();

        reset_exp = '{`USER_IDLE, 1'b1, 1'b0, 1'b0, 12'd0, 5'd0, 16'd0, 1'b0};
        repeat (3) @(posedge clk_sys);
        #1;
        arst_n = 1'b1;
        // No edge since release, registers still at their reset values
        errs_before = error_count;
        compare_outputs("reset", reset_exp);
        report_test("reset", errs_before);

        for (int i = 0; i < N_VEC; i++) begin
            apply_vector(vectors[i]);
            repeat (HOLD_CYCLES) @(posedge clk_sys);
            #1;
            errs_before = error_count;
            compare_outputs(vectors[i].name, reference_outputs(vectors[i]));
            report_test(vectors[i].name, errs_before);
        end

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 N_VEC + 1, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hdl
+incdir+sim
hdl/board_cfg_pkg.sv
hdl/video_crop_pkg.sv
hdl/osd_cfg_if.sv
hdl/status_decode.sv
hdl/crop_calc.sv
hdl/user_port_ctrl.sv
hdl/menu_mask_gen.sv
hdl/osd_video_ctrl.sv
sim/tb_osd_video_ctrl.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_osd_video_ctrl \
    -o tb_osd_video_ctrl

./obj_dir/tb_osd_video_ctrl > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
